// File: verilog.f
design/ctrl_pkg.sv
design/game_pkg.sv
design/clock_enables.sv
design/dl_config_regs.sv
design/input_port_mapper.sv
design/arcade_inputs_top.sv
verif/tb_arcade_inputs.sv

// File: Makefile
TOP = tb_arcade_inputs

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module arcade_inputs_top \
		design/ctrl_pkg.sv design/game_pkg.sv design/clock_enables.sv \
		design/dl_config_regs.sv design/input_port_mapper.sv design/arcade_inputs_top.sv

sim:
	verilator --binary --timing --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: verif/tb_arcade_inputs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_inputs;

	import ctrl_pkg::*;
	import game_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_ROWS   = 18;
	localparam int RAND_SEED  = 32'h67dd;

	// Joystick bits the ports never read, filled with noise
	localparam joy_t NOISE_MASK = 32'hFFFF_F800;

	localparam joy_t J_RIGHT  = joy_t'(1) << JOY_RIGHT;
	localparam joy_t J_LEFT   = joy_t'(1) << JOY_LEFT;
	localparam joy_t J_DOWN   = joy_t'(1) << JOY_DOWN;
	localparam joy_t J_UP     = joy_t'(1) << JOY_UP;
	localparam joy_t J_FIRE_A = joy_t'(1) << JOY_FIRE_A;
	localparam joy_t J_FIRE_B = joy_t'(1) << JOY_FIRE_B;
	localparam joy_t J_FIRE_C = joy_t'(1) << JOY_FIRE_C;
	localparam joy_t J_START1 = joy_t'(1) << JOY_START1;
	localparam joy_t J_START2 = joy_t'(1) << JOY_START2;
	localparam joy_t J_COIN   = joy_t'(1) << JOY_COIN;

	// One test step, DIP bytes and ports are packed as {0, 1, 2, 3} and {a, b, c, d}
	typedef struct packed {
		game_t       game;
		logic [31:0] dips;
		joy_t        joy1;
		joy_t        joy2;
		logic [31:0] ports;
		hwsel_t      hwsel;
		logic        galaxian;
		logic        landscape;
	} row_t;

	row_t  rows [NUM_ROWS];
	string names [NUM_ROWS];
	int    n_rows;

	logic clk_sys = 1'b0;
	logic reset;
	logic dl_wr;
	logic [DL_INDEX_W-1:0] dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	port_t dl_data;
	joy_t joy1;
	joy_t joy2;
	logic ce_12, ce_6p, ce_6n, ce_1p79;
	port_t port_a, port_b, port_c, port_d;
	hwsel_t hwsel;
	logic galaxian_video;
	logic landscape;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	arcade_inputs_top #(
		.CE_SLOW_DIV(14),
		.NUM_DIPS(4)
	) dut0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_wr          (dl_wr),
		.dl_index       (dl_index),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data),
		.joy1           (joy1),
		.joy2           (joy2),
		.ce_12          (ce_12),
		.ce_6p          (ce_6p),
		.ce_6n          (ce_6n),
		.ce_1p79        (ce_1p79),
		.port_a         (port_a),
		.port_b         (port_b),
		.port_c         (port_c),
		.port_d         (port_d),
		.hwsel          (hwsel),
		.galaxian_video (galaxian_video),
		.landscape      (landscape)
	);

	// ==========================================================
	// Failure reporting and compare tasks
	// ==========================================================
	task automatic stop_on_failure(string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_port(string name, port_t exp, port_t act);
		if (act !== exp)
			stop_on_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_hwsel(string name, hwsel_t exp, hwsel_t act);
		if (act !== exp)
			stop_on_failure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp)
			stop_on_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp)
			stop_on_failure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// ==========================================================
	// Stimulus table
	// ==========================================================
	task automatic add_row(string name, game_t game, logic [31:0] dips, joy_t j1, joy_t j2,
		logic [31:0] ports, hwsel_t hw, logic gal, logic land);
		names[n_rows] = name;
		rows[n_rows]  = '{game, dips, j1, j2, ports, hw, gal, land};
		n_rows++;
	endtask

	task automatic build_table();
		n_rows = 0;
		add_row("scramble_idle", GAME_SCRAMBLE, 32'hFFFF_FFFF, '0, '0,
			32'hFF_FF_FF_FF, 8'd0, 1'b0, 1'b0);
		add_row("scramble_fire", GAME_SCRAMBLE, 32'hFFFF_FFFF, J_COIN | J_FIRE_A | J_UP, '0,
			32'h76_F7_EF_FF, 8'd0, 1'b0, 1'b0);
		add_row("scramble_joy2", GAME_SCRAMBLE, 32'hFFFF_FFFF, '0, J_COIN | J_FIRE_A | J_UP,
			32'h76_F7_EF_FF, 8'd0, 1'b0, 1'b0);
		add_row("scramble_merge", GAME_SCRAMBLE, 32'hFFFF_FFFF, J_LEFT | J_DOWN,
			J_START1 | J_FIRE_B, 32'hDD_5B_BE_FF, 8'd0, 1'b0, 1'b0);
		add_row("frogger", GAME_FROGGER, 32'hFFFF_FFFF, J_RIGHT | J_START2, '0,
			32'hEF_AF_FF_FF, HW_FROGGER, 1'b0, 1'b0);
		add_row("tazman_coin", GAME_TAZMAN, 32'hFFFF_FFFF, J_COIN | J_DOWN | J_FIRE_B,
			J_START2, 32'h76_FF_BF_FF, HW_TAZMAN, 1'b0, 1'b0);
		add_row("tazman_start", GAME_TAZMAN, 32'hFFFF_FFFF, J_UP | J_FIRE_A | J_START1, '0,
			32'hF9_FF_FE_FF, HW_TAZMAN, 1'b0, 1'b0);
		add_row("calipso_start", GAME_CALIPSO, 32'hFFFF_FFFF, J_LEFT | J_UP | J_START2, '0,
			32'hDA_DB_FF_FF, HW_CALIPSO, 1'b0, 1'b0);
		add_row("calipso_fire", GAME_CALIPSO, 32'hFFFF_FFFF, '0, J_FIRE_A | J_RIGHT | J_DOWN,
			32'hE6_E7_FE_FF, HW_CALIPSO, 1'b0, 1'b0);
		add_row("anteater_up", GAME_ANTEATER, 32'hFFFF_FFFF, J_FIRE_A | J_UP, J_COIN,
			32'h7A_B7_FF_FF, HW_ANTEATER, 1'b0, 1'b0);
		add_row("anteater_down", GAME_ANTEATER, 32'hFFFF_FFFF, J_DOWN | J_START1 | J_START2,
			'0, 32'hF7_FB_BE_FF, HW_ANTEATER, 1'b0, 1'b0);
		add_row("theend", GAME_THEEND, 32'hFFFF_FFFF, J_FIRE_B | J_RIGHT, '0,
			32'hED_EB_FF_FF, 8'd0, 1'b1, 1'b0);
		add_row("stratgyx", GAME_STRATGYX, 32'hFFFF_FFFF, J_FIRE_C | J_DOWN, J_UP,
			32'hFE_FF_0E_FF, HW_STRATGYX, 1'b0, 1'b1);
		add_row("turtles", GAME_TURTLES, 32'hFFFF_FFFF,
			J_COIN | J_FIRE_A | J_FIRE_B | J_UP | J_START1, '0,
			32'h76_77_EF_FF, HW_TURTLES, 1'b0, 1'b0);
		add_row("unknown_game", 8'd7, 32'hFFFF_FFFF, J_COIN | J_FIRE_A | J_UP, '0,
			32'h76_F7_EF_FF, 8'd0, 1'b0, 1'b0);
		add_row("dip_mask_idle", GAME_SCRAMBLE, 32'h0F_F0_3C_55, '0, '0,
			32'h0F_F0_3C_55, 8'd0, 1'b0, 1'b0);
		add_row("dip_mask_joy", GAME_SCRAMBLE, 32'hFE_7F_FF_AA, J_FIRE_A | J_UP, '0,
			32'hF6_77_EF_AA, 8'd0, 1'b0, 1'b0);
		add_row("dip_restore", GAME_STRATGYX, 32'hFFFF_FFFF, '0, '0,
			32'hFF_FF_FF_FF, HW_STRATGYX, 1'b0, 1'b1);
	endtask

	// ==========================================================
	// Bus drivers
	// ==========================================================
	task automatic dl_write(logic [DL_INDEX_W-1:0] index, int addr, port_t data);
		@(posedge clk_sys);
		dl_wr    <= 1'b1;
		dl_index <= index;
		dl_addr  <= DL_ADDR_W'(addr);
		dl_data  <= data;
	endtask

	// Game write two cycles ahead of the check, sticks one cycle ahead
	task automatic apply_row(int i);
		for (int a = 0; a < 4; a++)
			dl_write(DL_INDEX_DIP, a, rows[i].dips[31 - 8 * a -: 8]);
		// Neither of these may reach the DIP bytes
		dl_write(DL_INDEX_DIP, 5, 8'h00);
		dl_write(8'd3, 0, 8'h00);
		dl_write(DL_INDEX_GAME, 0, rows[i].game);
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		joy1  <= rows[i].joy1 | (joy_t'($urandom()) & NOISE_MASK);
		joy2  <= rows[i].joy2 | (joy_t'($urandom()) & NOISE_MASK);
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic check_row(int i);
		check_port($sformatf("%s port_a", names[i]), rows[i].ports[31:24], port_a);
		check_port($sformatf("%s port_b", names[i]), rows[i].ports[23:16], port_b);
		check_port($sformatf("%s port_c", names[i]), rows[i].ports[15:8], port_c);
		check_port($sformatf("%s port_d", names[i]), rows[i].ports[7:0], port_d);
		check_hwsel($sformatf("%s hwsel", names[i]), rows[i].hwsel, hwsel);
		check_flag($sformatf("%s galaxian_video", names[i]), rows[i].galaxian, galaxian_video);
		check_flag($sformatf("%s landscape", names[i]), rows[i].landscape, landscape);
	endtask

	task automatic count_enables();
		int n_12;
		int n_6p;
		int n_6n;
		int n_1p79;
		n_12   = 0;
		n_6p   = 0;
		n_6n   = 0;
		n_1p79 = 0;
		repeat (28)
		begin
			@(negedge clk_sys);
			n_12   += int'(ce_12);
			n_6p   += int'(ce_6p);
			n_6n   += int'(ce_6n);
			n_1p79 += int'(ce_1p79);
		end
		check_count("ce_12 count", 14, n_12);
		check_count("ce_6p count", 7, n_6p);
		check_count("ce_6n count", 7, n_6n);
		check_count("ce_1p79 count", 2, n_1p79);
	endtask

	// Watchdog sized from the table length
	initial
	begin
		#(CLK_PERIOD * (NUM_ROWS * 10 + 200));
		stop_on_failure("Timeout: the test did not finish in the expected time");
	end

	initial
	begin
		void'($urandom(RAND_SEED));
		reset    = 1'b1;
		dl_wr    = 1'b0;
		dl_index = '0;
		dl_addr  = '0;
		dl_data  = '0;
		joy1     = '0;
		joy2     = '0;
		build_table();

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		check_port("reset port_a", 8'hFF, port_a);
		check_port("reset port_b", 8'hFF, port_b);
		check_port("reset port_c", 8'hFF, port_c);
		check_port("reset port_d", 8'hFF, port_d);
		check_hwsel("reset hwsel", 8'd0, hwsel);
		check_flag("reset galaxian_video", 1'b0, galaxian_video);
		check_flag("reset landscape", 1'b0, landscape);
		check_flag("reset ce_12", 1'b0, ce_12);
		check_flag("reset ce_6p", 1'b0, ce_6p);
		check_flag("reset ce_6n", 1'b0, ce_6n);
		check_flag("reset ce_1p79", 1'b0, ce_1p79);

		count_enables();

		for (int i = 0; i < n_rows; i++)
		begin
			apply_row(i);
			check_row(i);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/arcade_inputs_top.sv
`timescale 1ns/1ps
`default_nettype none

module arcade_inputs_top #(
	parameter int CE_SLOW_DIV = 14,
	parameter int NUM_DIPS    = 4
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_wr,
	input  logic [ctrl_pkg::DL_INDEX_W-1:0] dl_index,
	input  logic [ctrl_pkg::DL_ADDR_W-1:0] dl_addr,
	input  ctrl_pkg::port_t dl_data,
	input  ctrl_pkg::joy_t joy1,
	input  ctrl_pkg::joy_t joy2,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79,
	output ctrl_pkg::port_t port_a,
	output ctrl_pkg::port_t port_b,
	output ctrl_pkg::port_t port_c,
	output ctrl_pkg::port_t port_d,
	output game_pkg::hwsel_t hwsel,
	output logic galaxian_video,
	output logic landscape
);

	import ctrl_pkg::*;
	import game_pkg::*;

	// Configuration from the download stream
	game_t game;
	port_t dips [NUM_DIPS];

	clock_enables #(
		.CE_SLOW_DIV(CE_SLOW_DIV)
	) u_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_1p79 (ce_1p79)
	);

	dl_config_regs #(
		.NUM_DIPS(NUM_DIPS)
	) u_dl_config_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dips     (dips)
	);

	input_port_mapper #(
		.NUM_DIPS(NUM_DIPS)
	) u_input_port_mapper (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.joy1           (joy1),
		.joy2           (joy2),
		.game           (game),
		.dips           (dips),
		.port_a         (port_a),
		.port_b         (port_b),
		.port_c         (port_c),
		.port_d         (port_d),
		.hwsel          (hwsel),
		.galaxian_video (galaxian_video),
		.landscape      (landscape)
	);

endmodule

`default_nettype wire

// File: design/input_port_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module input_port_mapper #(
	parameter int NUM_DIPS = 4
) (
	input  logic clk_sys,
	input  logic reset,
	input  ctrl_pkg::joy_t joy1,
	input  ctrl_pkg::joy_t joy2,
	input  game_pkg::game_t game,
	input  ctrl_pkg::port_t dips [NUM_DIPS],
	output ctrl_pkg::port_t port_a,
	output ctrl_pkg::port_t port_b,
	output ctrl_pkg::port_t port_c,
	output ctrl_pkg::port_t port_d,
	output game_pkg::hwsel_t hwsel,
	output logic galaxian_video,
	output logic landscape
);

	import ctrl_pkg::*;
	import game_pkg::*;

	if (NUM_DIPS < 4)
	begin : g_dip_check
		$error("input_port_mapper needs one DIP byte per port");
	end

	// ==========================================================
	// Merged controls, either stick drives the game
	// ==========================================================
	joy_t ctl;
	logic m_right, m_left, m_down, m_up;
	logic m_fire_a, m_fire_b, m_fire_c;
	logic m_start1, m_start2, m_coin;

	assign ctl      = joy1 | joy2;
	assign m_right  = ctl[JOY_RIGHT];
	assign m_left   = ctl[JOY_LEFT];
	assign m_down   = ctl[JOY_DOWN];
	assign m_up     = ctl[JOY_UP];
	assign m_fire_a = ctl[JOY_FIRE_A];
	assign m_fire_b = ctl[JOY_FIRE_B];
	assign m_fire_c = ctl[JOY_FIRE_C];
	assign m_start1 = ctl[JOY_START1];
	assign m_start2 = ctl[JOY_START2];
	assign m_coin   = ctl[JOY_COIN];

	// ==========================================================
	// Per-game port layout, active low
	// ==========================================================
	port_t raw_a, raw_b, raw_c;
	hwsel_t hw_next;
	logic galaxian_next;
	logic landscape_next;

	always_comb
	begin
		// Scramble wiring, used by any game not listed
		raw_a = ~{m_coin, 1'b0, m_left, m_right, m_fire_a, 1'b0, m_fire_b, m_up};
		raw_b = ~{m_start1, m_start2, m_left, m_right, m_fire_a, m_fire_b, 2'b00};
		raw_c = ~{1'b0, m_down, 1'b0, m_up, 3'b000, m_down};
		hw_next        = '0;
		galaxian_next  = 1'b0;
		landscape_next = 1'b0;

		case (game)
			GAME_FROGGER:
			begin
				hw_next = HW_FROGGER;
			end
			GAME_TAZMAN:
			begin
				hw_next = HW_TAZMAN;
				raw_a = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, m_fire_a, m_fire_b};
				raw_b = 8'hFF;
				raw_c = ~{1'b0, m_start2, 5'b00000, m_start1};
			end
			GAME_CALIPSO:
			begin
				hw_next = HW_CALIPSO;
				raw_a = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0,
					m_start2 | m_fire_a};
				raw_b = ~{2'b00, m_left, m_right, m_down, m_up, 2'b00};
				raw_c = ~{7'b0000000, m_fire_a | m_start1};
			end
			GAME_ANTEATER:
			begin
				hw_next = HW_ANTEATER;
				raw_a = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0, m_fire_a};
				// up and down swap places on this port
				raw_b = ~{1'b0, m_fire_a, m_left, m_right, m_up, m_down, 2'b00};
				raw_c = ~{1'b0, m_start2, 5'b00000, m_start1};
			end
			GAME_THEEND:
			begin
				galaxian_next = 1'b1;
			end
			GAME_STRATGYX:
			begin
				hw_next        = HW_STRATGYX;
				landscape_next = 1'b1;
				raw_c = ~{m_fire_c, m_down, m_fire_c, m_up, 3'b000, m_down};
			end
			GAME_TURTLES:
			begin
				hw_next = HW_TURTLES;
				raw_a = ~{m_coin, 1'b0, m_left, m_right, m_fire_a, 2'b00, m_up};
				raw_b = ~{m_start1, m_start2, m_left, m_right, m_fire_a, 3'b000};
			end
			default:
			begin
				// Scramble layout as set above
			end
		endcase
	end

	// DIP masking and output register
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			port_a         <= '1;
			port_b         <= '1;
			port_c         <= '1;
			port_d         <= '1;
			hwsel          <= '0;
			galaxian_video <= 1'b0;
			landscape      <= 1'b0;
		end
		else
		begin
			port_a         <= raw_a & dips[0];
			port_b         <= raw_b & dips[1];
			port_c         <= raw_c & dips[2];
			// Port D has no controls, only its DIP byte
			port_d         <= dips[3];
			hwsel          <= hw_next;
			galaxian_video <= galaxian_next;
			landscape      <= landscape_next;
		end
	end

	// Ports stay clean once out of reset, whatever the download block holds
	a_ports_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({port_a, port_b, port_c, port_d}));

endmodule

`default_nettype wire

// File: design/dl_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dl_config_regs #(
	parameter int NUM_DIPS = 4
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_wr,
	input  logic [ctrl_pkg::DL_INDEX_W-1:0] dl_index,
	input  logic [ctrl_pkg::DL_ADDR_W-1:0] dl_addr,
	input  ctrl_pkg::port_t dl_data,
	output game_pkg::game_t game,
	output ctrl_pkg::port_t dips [NUM_DIPS]
);

	import ctrl_pkg::*;
	import game_pkg::*;

	localparam int SEL_W = (NUM_DIPS > 1) ? $clog2(NUM_DIPS) : 1;

	logic game_we;
	logic dip_we;

	// Only the DIP bytes the board reads are kept
	assign game_we = dl_wr && (dl_index == DL_INDEX_GAME);
	assign dip_we  = dl_wr && (dl_index == DL_INDEX_DIP)
		&& (dl_addr < DL_ADDR_W'(NUM_DIPS));

	// ==========================================================
	// Game select byte
	// ==========================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			game <= GAME_SCRAMBLE;
		else if (game_we)
			game <= dl_data;
	end

	// ==========================================================
	// DIP switch bytes, one per input port
	// ==========================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_DIPS; i++)
				dips[i] <= DIP_DEFAULT;
		end
		else if (dip_we)
			dips[dl_addr[SEL_W-1:0]] <= dl_data;
	end

	// Host must drive a clean index and address with each strobe
	a_dl_known: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> !$isunknown({dl_index, dl_addr}));

endmodule

`default_nettype wire

// File: design/clock_enables.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enables #(
	parameter int CE_SLOW_DIV = 14
) (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	localparam int SLOW_W = $clog2(CE_SLOW_DIV + 1);

	// Fast divider, bit 0 toggles at half rate
	logic [1:0] div;
	// Slow divider counts down to zero, then reloads
	logic [SLOW_W-1:0] slow_cnt;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			div      <= '0;
			slow_cnt <= '0;
			ce_12    <= 1'b0;
			ce_6p    <= 1'b0;
			ce_6n    <= 1'b0;
			ce_1p79  <= 1'b0;
		end
		else
		begin
			div <= div + 2'd1;

			// Two 6 MHz phases sit two cycles apart
			ce_12 <= div[0];
			ce_6p <= div[0] & ~div[1];
			ce_6n <= div[0] & div[1];

			if (slow_cnt == '0)
			begin
				slow_cnt <= SLOW_W'(CE_SLOW_DIV - 1);
				ce_1p79  <= 1'b1;
			end
			else
			begin
				slow_cnt <= slow_cnt - 1'b1;
				ce_1p79  <= 1'b0;
			end
		end
	end

	// Video phase comes alone, two cycles after the CPU phase
	a_phase_excl: assert property (@(posedge clk_sys) disable iff (reset)
		ce_6n |-> (!ce_6p && $past(ce_6p, 2)));

endmodule

`default_nettype wire

// File: design/game_pkg.sv
`default_nettype none

package game_pkg;

	// ==========================================================
	// Game numbers as sent on download index 1
	// ==========================================================

	typedef logic [7:0] game_t;

	localparam game_t GAME_SCRAMBLE = 8'd0;
	localparam game_t GAME_FROGGER  = 8'd2;
	localparam game_t GAME_TAZMAN   = 8'd4;
	localparam game_t GAME_CALIPSO  = 8'd8;
	localparam game_t GAME_ANTEATER = 8'd10;
	localparam game_t GAME_THEEND   = 8'd12;
	localparam game_t GAME_STRATGYX = 8'd14;
	localparam game_t GAME_TURTLES  = 8'd15;

	// ==========================================================
	// Hardware variant numbers for the board core
	// ==========================================================

	typedef logic [7:0] hwsel_t;

	// Scramble and theend run on variant 0
	localparam hwsel_t HW_FROGGER  = 8'd1;
	localparam hwsel_t HW_TAZMAN   = 8'd2;
	localparam hwsel_t HW_CALIPSO  = 8'd3;
	localparam hwsel_t HW_STRATGYX = 8'd5;
	localparam hwsel_t HW_ANTEATER = 8'd6;
	localparam hwsel_t HW_TURTLES  = 8'd11;

	// DIP byte until the host sends one, all switches open
	localparam logic [7:0] DIP_DEFAULT = 8'hFF;

endpackage

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// Width of one input port or DIP byte
	localparam int PORT_W = 8;

	typedef logic [PORT_W-1:0] port_t;
	typedef logic [31:0] joy_t;

	// Joystick word, direction and fire bits
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;

	// Shared buttons, taken from the merged word
	localparam int JOY_START1 = 8;
	localparam int JOY_START2 = 9;
	localparam int JOY_COIN   = 10;

	// Download stream
	localparam int DL_ADDR_W  = 25;
	localparam int DL_INDEX_W = 8;
	localparam logic [DL_INDEX_W-1:0] DL_INDEX_GAME = 8'd1;
	localparam logic [DL_INDEX_W-1:0] DL_INDEX_DIP  = 8'd254;

endpackage

`default_nettype wire
